/* hw/access_check.sv */
//***********************************************************
// page fault flags from the current PDR, runs beside the
// relocation and is valid only with a strobe and mapping on
//***********************************************************
`timescale 1ns/1ps

module access_check (
   input  mmu_pkg::cpu_req_t    req_i,
   input  logic                 stb_i,
   input  mmu_pkg::page_desc_t  page_i,
   input  logic                 mmu_en_i,
   output mmu_pkg::fault_t      fault_o
);

   logic       active;    // mapped bus cycle in progress
   logic [6:0] va_blk;
   logic [6:0] plf;       // page length field
   logic       ed;        // 1 = page grows downward
   logic [2:0] acc;       // access control code
   logic       len_bad;

   assign active = mmu_en_i && stb_i;
   assign va_blk = req_i.addr[12:6];
   assign plf    = page_i.pdr[14:8];
   assign ed     = page_i.pdr[3];
   assign acc    = page_i.pdr[2:0];

   // upward pages end at plf, downward ones start there
   assign len_bad = ed ? (va_blk < plf) : (va_blk > plf);

   assign fault_o.nonres = active && mmu_pkg::acc_nonres(acc);
   assign fault_o.length = active && len_bad;
   assign fault_o.rdonly = active && req_i.we && mmu_pkg::acc_rdonly(acc);

endmodule

/* hw/bus_sequencer.sv */
//***********************************************************
// bus cycle control and MMR0, combines relocation and fault
// results into register cycles, memory strobes or an abort
//***********************************************************
`timescale 1ns/1ps

module bus_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  mmu_pkg::cpu_req_t         req_i,
   input  logic                      cpu_stb_i,
   input  mmu_pkg::xlat_t            xlat_i,
   input  mmu_pkg::fault_t           fault_i,
   input  logic                      reg_hit_i,
   input  logic [15:0]               reg_rdata_i,
   input  logic                      mem_ack_i,
   input  logic [15:0]               mem_rdata_i,
   input  logic                      ack_abort_i,
   input  logic                      ifetch_i,
   output logic                      mmu_en_o,
   output logic                      reg_wr_en_o,
   output logic                      reg_rd_en_o,
   output logic                      cpu_ack_o,
   output logic [15:0]               cpu_rdata_o,
   output logic                      abort_o,
   output logic [mmu_pkg::PA_W-1:0]  mem_adr_o,
   output logic                      ram_stb_o,
   output logic                      iopage_stb_o
);

   typedef enum logic [2:0] {
      S_IDLE,    // wait for a strobe
      S_REG,     // register cycle, enables out
      S_REG2,    // read data held, ack next
      S_MEM,     // RAM or I/O page strobe out
      S_REPLY    // ack to the CPU
   } state_t;

   state_t         state;

   // MMR0 fields, bit 4 and 12:7 read 0
   logic           mmr0_en;
   logic [2:0]     mmr0_err;    // nonres, length, rdonly
   mmu_pkg::mode_t mmr0_mode;
   logic [2:0]     mmr0_page;
   logic [15:0]    mmr0_rd;

   logic abort_held;    // raised, waiting for ack_abort_i
   logic block_abort;   // enable write until next ifetch
   logic abort_now;
   logic mmr0_hit;
   logic reg_tgt;
   logic accept;

   assign mmr0_hit = xlat_i.iopage && (xlat_i.paddr[12:1] == mmu_pkg::MMR0_ADDR[12:1]);
   assign reg_tgt  = reg_hit_i || mmr0_hit;   // one of our own registers
   assign mmr0_rd  = {mmr0_err, 6'b000000, mmr0_mode, 1'b0, mmr0_page, mmr0_en};

   // abort is combinational on the first strobe cycle, then held
   assign abort_now = (state == S_IDLE) && cpu_stb_i && (|fault_i) && !block_abort;
   assign abort_o   = abort_now || abort_held;
   assign accept    = (state == S_IDLE) && cpu_stb_i && !abort_o;

   assign reg_wr_en_o = (state == S_REG) && req_i.we;
   assign reg_rd_en_o = (state == S_REG) && !req_i.we;
   assign mmu_en_o    = mmr0_en;

   //***********************************************************
   // cycle FSM
   //***********************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= S_IDLE;
         cpu_ack_o    <= 1'b0;
         ram_stb_o    <= 1'b0;
         iopage_stb_o <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (accept && reg_tgt) begin
                  state <= S_REG;
               end else if (accept) begin
                  ram_stb_o    <= xlat_i.ram;
                  iopage_stb_o <= !xlat_i.ram;   // outer bus gets the top 256 KB
                  state        <= S_MEM;
               end
            end
            S_REG:
               state <= S_REG2;
            S_REG2: begin
               cpu_ack_o <= 1'b1;
               state     <= S_REPLY;
            end
            S_MEM: begin
               if (mem_ack_i) begin   // slow memory just keeps us here
                  ram_stb_o    <= 1'b0;
                  iopage_stb_o <= 1'b0;
                  cpu_ack_o    <= 1'b1;
                  state        <= S_REPLY;
               end
            end
            S_REPLY: begin
               cpu_ack_o <= 1'b0;
               state     <= S_IDLE;
            end
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // address and read data path
   always_ff @(posedge clk) begin
      if (accept)
         mem_adr_o <= xlat_i.paddr;
      if (state == S_REG)
         cpu_rdata_o <= mmr0_hit ? mmr0_rd : reg_rdata_i;
      else if ((state == S_MEM) && mem_ack_i)
         cpu_rdata_o <= mem_rdata_i;
   end

   //***********************************************************
   // MMR0 and abort control
   //***********************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         mmr0_en     <= 1'b0;
         mmr0_err    <= 3'b000;
         mmr0_mode   <= 2'b00;
         mmr0_page   <= 3'b000;
         abort_held  <= 1'b0;
         block_abort <= 1'b0;
      end else begin
         if (ifetch_i)
            block_abort <= 1'b0;
         if (ack_abort_i)
            abort_held <= 1'b0;
         else if (abort_now)
            abort_held <= 1'b1;
         // fault record, frozen until software clears 15:13
         if (abort_now && (mmr0_err == 3'b000)) begin
            mmr0_err  <= {fault_i.nonres, fault_i.length, fault_i.rdonly};
            mmr0_mode <= req_i.mode;
            mmr0_page <= req_i.addr[15:13];
         end
         if (reg_wr_en_o && mmr0_hit) begin
            if (req_i.sel[0]) begin
               mmr0_en     <= req_i.wdata[0];
               mmr0_mode   <= req_i.wdata[6:5];
               mmr0_page   <= req_i.wdata[3:1];
               block_abort <= req_i.wdata[0];   // no abort until next ifetch
            end
            if (req_i.sel[1])
               mmr0_err <= req_i.wdata[15:13];
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) !(ram_stb_o && iopage_stb_o))
      else $error("bus_sequencer: RAM and I/O page strobes together");
   assert property (@(posedge clk) disable iff (reset)
                    !(abort_o && (ram_stb_o || iopage_stb_o)))
      else $error("bus_sequencer: abort during a memory strobe");

endmodule

/* hw/mmu_pkg.sv */
//***********************************************************
// shared widths, register map, access codes and bus structs
// of the MMU, referred to by mmu_pkg:: names in every module
//***********************************************************
package mmu_pkg;

   localparam int VA_W  = 16;   // virtual address
   localparam int PA_W  = 22;   // physical address
   localparam int PAGES = 8;    // pages per mode, no I/D split

   // processor mode, supervisor codes count as invalid
   typedef logic [1:0] mode_t;
   localparam mode_t MODE_KERNEL = 2'b00;
   localparam mode_t MODE_USER   = 2'b11;

   //***********************************************************
   // register map, 22-bit physical addresses in octal
   //***********************************************************
   localparam logic [PA_W-1:0] KPDR_BASE = 22'o17772300;   // kernel PDR0-7
   localparam logic [PA_W-1:0] KPAR_BASE = 22'o17772340;   // kernel PAR0-7
   localparam logic [PA_W-1:0] UPDR_BASE = 22'o17777600;   // user PDR0-7
   localparam logic [PA_W-1:0] UPAR_BASE = 22'o17777640;   // user PAR0-7
   localparam logic [PA_W-1:0] MMR0_ADDR = 22'o17777572;
   localparam logic [PA_W-1:0] MMR3_ADDR = 22'o17772516;

   localparam logic [8:0] IOPAGE_TAG = 9'o777;   // top 8 KB of physical space

   // PDR access field, 000/011/111 not resident
   function automatic logic acc_nonres(input logic [2:0] acc);
      return (acc == 3'b000) || (acc == 3'b011) || (acc == 3'b111);
   endfunction

   // 001/010 read only, the rest read/write
   function automatic logic acc_rdonly(input logic [2:0] acc);
      return (acc == 3'b001) || (acc == 3'b010);
   endfunction

   // processor request, held stable for the whole cycle
   typedef struct packed {
      logic [VA_W-1:0] addr;    // virtual address
      logic            we;      // write cycle
      logic [1:0]      sel;     // byte enables
      logic [15:0]     wdata;
      mode_t           mode;    // current processor mode
   } cpu_req_t;

   // relocation result
   typedef struct packed {
      logic [PA_W-1:0] paddr;
      logic            iopage;  // bits 21:13 all ones
      logic            ram;     // below the top 256 KB
   } xlat_t;

   // access check result, MMR0 15:13 order
   typedef struct packed {
      logic nonres;
      logic length;
      logic rdonly;
   } fault_t;

   // current page, pdr in register bit format
   typedef struct packed {
      logic [15:0] par;
      logic [15:0] pdr;
   } page_desc_t;

endpackage

/* hw/mmu_top.sv */
//***********************************************************
// MMU top level, register file, relocation, access check
// and bus sequencer wired between the CPU and memory
//***********************************************************
`timescale 1ns/1ps

module mmu_top #(
   parameter bit RESET_MMR3_22 = 1'b0   // 22-bit mode out of reset
) (
   input  logic                      clk,
   input  logic                      reset,
   input  mmu_pkg::cpu_req_t         cpu_req_i,
   input  logic                      cpu_stb_i,
   input  logic                      ack_abort_i,
   input  logic                      ifetch_i,
   input  logic                      mem_ack_i,
   input  logic [15:0]               mem_rdata_i,
   output logic                      cpu_ack_o,
   output logic                      abort_o,
   output logic [15:0]               cpu_rdata_o,
   output logic [mmu_pkg::PA_W-1:0]  mem_adr_o,
   output logic                      ram_stb_o,
   output logic                      iopage_stb_o
);

   mmu_pkg::page_desc_t page;     // current PAR/PDR
   mmu_pkg::xlat_t      xlat;
   mmu_pkg::fault_t     fault;
   logic                mmu_en;   // MMR0 bit 0
   logic                mmu22;    // MMR3 bit 4, qualified
   logic                reg_hit;
   logic [15:0]         reg_rdata;
   logic                reg_wr_en;
   logic                reg_rd_en;

   page_reg_file #(
      .RESET_MMR3_22 (RESET_MMR3_22)
   ) u_page_reg_file (
      .clk         (clk),
      .reset       (reset),
      .req_i       (cpu_req_i),
      .mmu_en_i    (mmu_en),
      .paddr_i     (xlat.paddr),
      .reg_wr_en_i (reg_wr_en),
      .reg_rd_en_i (reg_rd_en),
      .page_o      (page),
      .reg_hit_o   (reg_hit),
      .reg_rdata_o (reg_rdata),
      .mmu22_o     (mmu22)
   );

   // relocation and checking side by side on the same page
   page_relocate u_page_relocate (
      .req_i    (cpu_req_i),
      .page_i   (page),
      .mmu_en_i (mmu_en),
      .mmu22_i  (mmu22),
      .xlat_o   (xlat)
   );

   access_check u_access_check (
      .req_i    (cpu_req_i),
      .stb_i    (cpu_stb_i),
      .page_i   (page),
      .mmu_en_i (mmu_en),
      .fault_o  (fault)
   );

   bus_sequencer u_bus_sequencer (
      .clk          (clk),
      .reset        (reset),
      .req_i        (cpu_req_i),
      .cpu_stb_i    (cpu_stb_i),
      .xlat_i       (xlat),
      .fault_i      (fault),
      .reg_hit_i    (reg_hit),
      .reg_rdata_i  (reg_rdata),
      .mem_ack_i    (mem_ack_i),
      .mem_rdata_i  (mem_rdata_i),
      .ack_abort_i  (ack_abort_i),
      .ifetch_i     (ifetch_i),
      .mmu_en_o     (mmu_en),
      .reg_wr_en_o  (reg_wr_en),
      .reg_rd_en_o  (reg_rd_en),
      .cpu_ack_o    (cpu_ack_o),
      .cpu_rdata_o  (cpu_rdata_o),
      .abort_o      (abort_o),
      .mem_adr_o    (mem_adr_o),
      .ram_stb_o    (ram_stb_o),
      .iopage_stb_o (iopage_stb_o)
   );

endmodule

/* hw/page_reg_file.sv */
//***********************************************************
// kernel and user PAR/PDR sets plus MMR3, register access
// and combinational lookup of the page in use
//***********************************************************
`timescale 1ns/1ps

module page_reg_file #(
   parameter bit RESET_MMR3_22 = 1'b0   // MMR3 bit 4 after reset
) (
   input  logic                         clk,
   input  logic                         reset,
   input  mmu_pkg::cpu_req_t            req_i,
   input  logic                         mmu_en_i,
   input  logic [mmu_pkg::PA_W-1:0]     paddr_i,
   input  logic                         reg_wr_en_i,
   input  logic                         reg_rd_en_i,
   output mmu_pkg::page_desc_t          page_o,
   output logic                         reg_hit_o,
   output logic [15:0]                  reg_rdata_o,
   output logic                         mmu22_o
);

   localparam int IDX_W = $clog2(2 * mmu_pkg::PAGES);

   // index is {user, page}
   logic [15:0] par_mem [2*mmu_pkg::PAGES];
   logic [10:0] pdr_mem [2*mmu_pkg::PAGES];   // {plf, ed, acc}
   logic        mmr3_22;                      // 22-bit mapping enable

   logic             kpdr_hit, kpar_hit, updr_hit, upar_hit, mmr3_hit;
   logic             par_sel, pdr_sel;
   logic [IDX_W-1:0] reg_idx;    // register being accessed
   logic [IDX_W-1:0] page_idx;   // page in use by the request
   logic             mode_ok;

   // stored fields back into the PDR layout
   function automatic logic [15:0] pdr_word(input logic [10:0] f);
      return {1'b0, f[10:4], 4'b0000, f[3:0]};
   endfunction

   //***********************************************************
   // address decode, eight words per register set
   //***********************************************************
   assign kpdr_hit = (paddr_i[21:4] == mmu_pkg::KPDR_BASE[21:4]);
   assign kpar_hit = (paddr_i[21:4] == mmu_pkg::KPAR_BASE[21:4]);
   assign updr_hit = (paddr_i[21:4] == mmu_pkg::UPDR_BASE[21:4]);
   assign upar_hit = (paddr_i[21:4] == mmu_pkg::UPAR_BASE[21:4]);
   assign mmr3_hit = (paddr_i[21:1] == mmu_pkg::MMR3_ADDR[21:1]);

   assign par_sel   = kpar_hit || upar_hit;
   assign pdr_sel   = kpdr_hit || updr_hit;
   assign reg_hit_o = par_sel || pdr_sel || mmr3_hit;
   assign reg_idx   = {updr_hit || upar_hit, paddr_i[3:1]};   // word within the set

   // byte writes, PDR keeps plf/ed/acc only
   always_ff @(posedge clk) begin
      if (reg_wr_en_i && par_sel) begin
         if (req_i.sel[0]) par_mem[reg_idx][7:0]  <= req_i.wdata[7:0];
         if (req_i.sel[1]) par_mem[reg_idx][15:8] <= req_i.wdata[15:8];
      end
      if (reg_wr_en_i && pdr_sel) begin
         if (req_i.sel[0]) pdr_mem[reg_idx][3:0]  <= req_i.wdata[3:0];    // ed, acc
         if (req_i.sel[1]) pdr_mem[reg_idx][10:4] <= req_i.wdata[14:8];   // plf
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mmr3_22 <= RESET_MMR3_22;
      end else if (reg_wr_en_i && mmr3_hit && req_i.sel[0]) begin
         mmr3_22 <= req_i.wdata[4];
      end
   end

   // read data only while the sequencer reads
   always_comb begin
      reg_rdata_o = '0;
      if (reg_rd_en_i) begin
         if (par_sel)
            reg_rdata_o = par_mem[reg_idx];
         else if (pdr_sel)
            reg_rdata_o = pdr_word(pdr_mem[reg_idx]);
         else if (mmr3_hit)
            reg_rdata_o = {11'b0, mmr3_22, 4'b0000};
      end
   end

   //***********************************************************
   // current page lookup
   //***********************************************************
   assign mode_ok  = (req_i.mode == mmu_pkg::MODE_KERNEL) ||
                     (req_i.mode == mmu_pkg::MODE_USER);
   assign page_idx = {req_i.mode == mmu_pkg::MODE_USER, req_i.addr[15:13]};

   assign page_o.par = mode_ok ? par_mem[page_idx] : '0;
   assign page_o.pdr = mode_ok ? pdr_word(pdr_mem[page_idx]) : '1;   // all ones, nonresident

   assign mmu22_o = mmr3_22 && mmu_en_i;   // 22-bit only counts with mapping on

   // enables come from the sequencer, one kind per cycle
   assert property (@(posedge clk) disable iff (reset) !(reg_wr_en_i && reg_rd_en_i))
      else $error("page_reg_file: register read and write in one cycle");

endmodule

/* hw/page_relocate.sv */
//***********************************************************
// virtual to physical address, MMU off, 18-bit and 22-bit
// mapping from the current PAR, plus target flags
//***********************************************************
`timescale 1ns/1ps

module page_relocate (
   input  mmu_pkg::cpu_req_t    req_i,
   input  mmu_pkg::page_desc_t  page_i,
   input  logic                 mmu_en_i,
   input  logic                 mmu22_i,
   output mmu_pkg::xlat_t       xlat_o
);

   logic [6:0]               va_blk;   // block within the page
   logic [11:0]              blk18;    // 64-byte block, 18-bit mode
   logic [15:0]              blk22;    // 64-byte block, 22-bit mode
   logic [mmu_pkg::PA_W-1:0] paddr;

   assign va_blk = req_i.addr[12:6];

   assign blk18 = page_i.par[11:0] + {5'b00000, va_blk};
   assign blk22 = page_i.par + {9'b000000000, va_blk};

   always_comb begin
      if (!mmu_en_i) begin
         // unmapped, page 7 lands in the I/O page
         if (req_i.addr[15:13] == 3'b111)
            paddr = {6'b111111, req_i.addr};
         else
            paddr = {6'b000000, req_i.addr};
      end else if (mmu22_i) begin
         paddr = {blk22, req_i.addr[5:0]};
      end else if (blk18[11:7] == 5'b11111) begin
         paddr = {4'b1111, blk18, req_i.addr[5:0]};   // top 8 KB of 18-bit space
      end else begin
         paddr = {4'b0000, blk18, req_i.addr[5:0]};
      end
   end

   assign xlat_o.paddr  = paddr;
   assign xlat_o.iopage = (paddr[21:13] == mmu_pkg::IOPAGE_TAG);
   assign xlat_o.ram    = (paddr[21:18] != 4'b1111);

endmodule

/* run_sim.sh */
#!/bin/sh
# compile the MMU testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module mmu_tb -o mmu_sim
./obj_dir/mmu_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
   echo "simulation ended without a result line, see sim.log"
   exit 1
fi
echo "simulation finished cleanly"

/* tb/mmu_tb_table.svh */
//***********************************************************
// MMU test table and random source, included in the body of
// the testbench module, rows are applied in order
//***********************************************************

localparam logic [31:0] LCG_SEED = 32'hc3a74afc;

// 32-bit LCG, upper bits give the memory wait states
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// op, mode, vaddr, wdata, sel, target, expected addr or data, abort
task automatic load_table();
   // MMU off, page 7 lands in the I/O page
   add_row(OP_RD, MK, 16'o000100, 16'h0000, 2'b11, T_RAM, 22'o00000100, 1'b0);
   add_row(OP_WR, MK, 16'o017776, 16'o123456, 2'b11, T_RAM, 22'o00017776, 1'b0);
   add_row(OP_RD, MK, 16'o160000, 16'h0000, 2'b11, T_IO, 22'o17760000, 1'b0);
   add_row(OP_RD, MU, 16'o177000, 16'h0000, 2'b11, T_IO, 22'o17777000, 1'b0);
   // PDR keeps plf, ed, acc only
   add_row(OP_WR, MK, 16'o172340, 16'o001000, 2'b11, T_REG, 22'h0, 1'b0);   // KPAR0
   add_row(OP_WR, MK, 16'o172300, 16'hffff, 2'b11, T_REG, 22'h0, 1'b0);     // KPDR0
   add_row(OP_RD, MK, 16'o172300, 16'h0000, 2'b11, T_REG, 22'h007f0f, 1'b0);
   add_row(OP_WR, MK, 16'o172300, 16'h7f06, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o172300, 16'h0000, 2'b11, T_REG, 22'h007f06, 1'b0);
   // byte selects on KPAR1 and KPDR1
   add_row(OP_WR, MK, 16'o172342, 16'h1234, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o172342, 16'hff56, 2'b01, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o172342, 16'h0000, 2'b11, T_REG, 22'h001256, 1'b0);
   add_row(OP_WR, MK, 16'o172302, 16'h7f06, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o172302, 16'h10ff, 2'b10, T_REG, 22'h0, 1'b0);     // plf 16
   add_row(OP_RD, MK, 16'o172302, 16'h0000, 2'b11, T_REG, 22'h001006, 1'b0);
   // kernel page 7 onto the I/O page, user pages 0-3
   add_row(OP_WR, MK, 16'o172356, 16'o177600, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o172316, 16'h7f06, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o177640, 16'o002000, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o177600, 16'h7f06, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o177642, 16'o000400, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o177602, 16'h7f02, 2'b11, T_REG, 22'h0, 1'b0);     // read only
   add_row(OP_WR, MK, 16'o177644, 16'o000000, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o177604, 16'h0000, 2'b11, T_REG, 22'h0, 1'b0);     // nonresident
   add_row(OP_WR, MK, 16'o177646, 16'o003000, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_WR, MK, 16'o177606, 16'h7c0e, 2'b11, T_REG, 22'h0, 1'b0);     // grows down
   add_row(OP_RD, MK, 16'o177646, 16'h0000, 2'b11, T_REG, 22'o00003000, 1'b0);
   // MMR3 22-bit bit, then back to 18-bit
   add_row(OP_WR, MK, 16'o172516, 16'h0010, 2'b01, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o172516, 16'h0000, 2'b11, T_REG, 22'h000010, 1'b0);
   add_row(OP_WR, MK, 16'o172516, 16'h0000, 2'b01, T_REG, 22'h0, 1'b0);
   // MMU on
   add_row(OP_WR, MK, 16'o177572, 16'h0001, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o177572, 16'h0000, 2'b11, T_REG, 22'h000001, 1'b0);
   // 18-bit relocation
   add_row(OP_RD, MK, 16'o000100, 16'h0000, 2'b11, T_RAM, 22'o00100100, 1'b0);
   add_row(OP_WR, MK, 16'o000200, 16'h4321, 2'b11, T_RAM, 22'o00100200, 1'b0);
   add_row(OP_RD, MU, 16'o000100, 16'h0000, 2'b11, T_RAM, 22'o00200100, 1'b0);
   add_row(OP_RD, MK, 16'o020100, 16'h0000, 2'b11, T_RAM, 22'h0095c0, 1'b0);
   add_row(OP_RD, MK, 16'o177000, 16'h0000, 2'b11, T_IO, 22'o17777000, 1'b0);
   add_row(OP_RD, MU, 16'o077500, 16'h0000, 2'b11, T_RAM, 22'o00317500, 1'b0);
   // 22-bit relocation
   add_row(OP_WR, MK, 16'o172516, 16'h0010, 2'b01, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o020100, 16'h0000, 2'b11, T_RAM, 22'h0495c0, 1'b0);
   add_row(OP_RD, MK, 16'o177000, 16'h0000, 2'b11, T_IO, 22'o17777000, 1'b0);
   // faults, MMR0 frozen until 15:13 cleared
   add_row(OP_WR, MU, 16'o020000, 16'h5555, 2'b11, T_NONE, 22'h0, 1'b1);
   add_row(OP_RD, MK, 16'o177572, 16'h0000, 2'b11, T_REG, 22'h002063, 1'b0);
   add_row(OP_RD, MU, 16'o040000, 16'h0000, 2'b11, T_NONE, 22'h0, 1'b1);
   add_row(OP_RD, MK, 16'o177572, 16'h0000, 2'b11, T_REG, 22'h002063, 1'b0);
   add_row(OP_WR, MK, 16'o177572, 16'h0001, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o022100, 16'h0000, 2'b11, T_NONE, 22'h0, 1'b1);   // past plf
   add_row(OP_RD, MK, 16'o177572, 16'h0000, 2'b11, T_REG, 22'h004003, 1'b0);
   add_row(OP_WR, MK, 16'o177572, 16'h0001, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MU, 16'o060000, 16'h0000, 2'b11, T_NONE, 22'h0, 1'b1);   // below plf
   add_row(OP_RD, MK, 16'o177572, 16'h0000, 2'b11, T_REG, 22'h004067, 1'b0);
   add_row(OP_WR, MK, 16'o177572, 16'h0001, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MX, 16'o000100, 16'h0000, 2'b11, T_NONE, 22'h0, 1'b1);   // invalid mode
   add_row(OP_RD, MK, 16'o177572, 16'h0000, 2'b11, T_REG, 22'h00c021, 1'b0);
   add_row(OP_WR, MK, 16'o177572, 16'h0001, 2'b11, T_REG, 22'h0, 1'b0);
   add_row(OP_RD, MK, 16'o000100, 16'h0000, 2'b11, T_RAM, 22'o00100100, 1'b0);
endtask

/* tb/mmu_tb.sv */
//***********************************************************
// MMU testbench, applies the table from mmu_tb_table.svh to
// the top level with a random-latency memory on the far side
//***********************************************************
`timescale 1ns/1ps

module mmu_tb;

   localparam int WAIT_LIMIT = 50;   // cycles per wait loop

   localparam logic [1:0] OP_RD = 2'd0;
   localparam logic [1:0] OP_WR = 2'd1;

   localparam logic [1:0] T_REG  = 2'd0;   // MMU register
   localparam logic [1:0] T_RAM  = 2'd1;
   localparam logic [1:0] T_IO   = 2'd2;   // I/O page strobe
   localparam logic [1:0] T_NONE = 2'd3;   // aborted with no target

   localparam mmu_pkg::mode_t MK = mmu_pkg::MODE_KERNEL;
   localparam mmu_pkg::mode_t MU = mmu_pkg::MODE_USER;
   localparam mmu_pkg::mode_t MX = 2'b01;   // supervisor code is invalid here

   // one table row
   typedef struct packed {
      logic [1:0]     op;
      mmu_pkg::mode_t mode;
      logic [15:0]    addr;
      logic [15:0]    data;
      logic [1:0]     sel;
      logic [1:0]     tgt;
      logic [21:0]    expv;    // physical address or read data
      logic           abrt;
   } row_t;

   logic                clk;
   logic                reset;
   mmu_pkg::cpu_req_t   cpu_req;
   logic                cpu_stb;
   logic                ack_abort;
   logic                ifetch;
   logic                mem_ack;
   logic [15:0]         mem_rdata;
   logic                cpu_ack;
   logic                abort;
   logic [15:0]         cpu_rdata;
   logic [21:0]         mem_adr;
   logic                ram_stb;
   logic                iopage_stb;

   row_t        rows [$];
   logic [31:0] lcg_state;
   int          errors;
   int          rows_run;
   int          rows_failed;
   logic        timed_out;

   `include "mmu_tb_table.svh"

   mmu_top #(
      .RESET_MMR3_22 (1'b0)
   ) u_mmu_top (
      .clk          (clk),
      .reset        (reset),
      .cpu_req_i    (cpu_req),
      .cpu_stb_i    (cpu_stb),
      .ack_abort_i  (ack_abort),
      .ifetch_i     (ifetch),
      .mem_ack_i    (mem_ack),
      .mem_rdata_i  (mem_rdata),
      .cpu_ack_o    (cpu_ack),
      .abort_o      (abort),
      .cpu_rdata_o  (cpu_rdata),
      .mem_adr_o    (mem_adr),
      .ram_stb_o    (ram_stb),
      .iopage_stb_o (iopage_stb)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 50 MHz
   end

   // every address bit shows up in the memory word
   function automatic logic [15:0] mem_data(input logic [21:0] a);
      return a[15:0] ^ {a[21:16], a[21:16], 4'b1010};
   endfunction

   task automatic add_row(input logic [1:0] op, input mmu_pkg::mode_t mode,
                          input logic [15:0] addr, input logic [15:0] data,
                          input logic [1:0] sel, input logic [1:0] tgt,
                          input logic [21:0] expv, input logic abrt);
      row_t r;
      r = '{op: op, mode: mode, addr: addr, data: data, sel: sel,
            tgt: tgt, expv: expv, abrt: abrt};
      rows.push_back(r);
   endtask

   task automatic check_val(input string name, input logic [21:0] got,
                            input logic [21:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %0o expected %0o", $time, name, got, exp);
         errors = errors + 1;
      end
   endtask

   //***********************************************************
   // memory model acking 0 to 5 cycles into the strobe
   //***********************************************************
   initial begin
      logic [31:0] rnd;
      int          mem_wait;
      logic        pending;
      mem_ack   = 1'b0;
      mem_rdata = 16'h0000;
      lcg_state = LCG_SEED;
      pending   = 1'b0;
      mem_wait  = 0;
      forever begin
         @(posedge clk);
         #1;
         mem_ack = 1'b0;   // ack is one cycle wide
         if (ram_stb || iopage_stb) begin
            if (!pending) begin
               rnd      = lcg_next();
               mem_wait = int'(rnd[31:16] % 16'd6);
               pending  = 1'b1;
            end
            if (mem_wait == 0) begin
               mem_ack   = 1'b1;
               mem_rdata = mem_data(mem_adr);
               pending   = 1'b0;
            end else begin
               mem_wait = mem_wait - 1;
            end
         end
      end
   end

   //***********************************************************
   // one CPU bus cycle per row
   //***********************************************************
   task automatic run_row(input int idx, input row_t r);
      int    n;
      int    err_before;
      logic  seen_ram, seen_io, got_ack, got_abort, is_rd;
      string kind, res;
      n          = 0;
      err_before = errors;
      seen_ram   = 1'b0;
      seen_io    = 1'b0;
      got_ack    = 1'b0;
      got_abort  = 1'b0;
      is_rd      = (r.op == OP_RD);
      // instruction boundary lifts any abort block
      @(posedge clk);
      #1;
      ifetch = 1'b1;
      @(posedge clk);
      #1;
      ifetch        = 1'b0;
      cpu_req.addr  = r.addr;
      cpu_req.we    = !is_rd;
      cpu_req.sel   = r.sel;
      cpu_req.wdata = r.data;
      cpu_req.mode  = r.mode;
      cpu_stb       = 1'b1;
      while (!got_ack && !got_abort && (n < WAIT_LIMIT)) begin
         @(negedge clk);   // mid-cycle while outputs are settled
         n = n + 1;
         if (ram_stb) seen_ram = 1'b1;
         if (iopage_stb) seen_io = 1'b1;
         if (cpu_ack) got_ack = 1'b1;
         if (abort) got_abort = 1'b1;
      end
      if (!got_ack && !got_abort) begin
         $display("Timeout at %0t ns: row %0d got neither an ack nor an abort", $time, idx);
         timed_out = 1'b1;
      end else begin
         check_val("abort_o", 22'(got_abort), 22'(r.abrt));
         check_val("ram_stb_o", 22'(seen_ram), 22'(r.tgt == T_RAM));
         check_val("iopage_stb_o", 22'(seen_io), 22'(r.tgt == T_IO));
         // accepting edge falls between samples 1 and 2
         if (r.abrt)
            check_val("abort_o cycle", 22'(n), 22'd1);
         else if (r.tgt == T_REG)
            check_val("cpu_ack_o delay", 22'(n - 2), 22'd2);
         if (!r.abrt && (r.tgt == T_REG) && is_rd)
            check_val("cpu_rdata_o", {6'b0, cpu_rdata}, r.expv);
         if (!r.abrt && (r.tgt != T_REG)) begin
            check_val("mem_adr_o", mem_adr, r.expv);
            if (is_rd)
               check_val("cpu_rdata_o", {6'b0, cpu_rdata}, {6'b0, mem_data(r.expv)});
         end
      end
      @(posedge clk);
      #1;
      if (got_ack)
         check_val("cpu_ack_o width", 22'(cpu_ack), 22'd0);   // one cycle wide
      if (got_abort) begin
         // the faulting request must not reach the bus after the edge
         check_val("ram_stb_o", 22'(ram_stb), 22'd0);
         check_val("iopage_stb_o", 22'(iopage_stb), 22'd0);
         check_val("abort_o held", 22'(abort), 22'd1);
      end
      cpu_stb = 1'b0;
      if (got_abort) begin
         ack_abort = 1'b1;   // CPU takes the abort
         @(posedge clk);
         #1;
         ack_abort = 1'b0;
         n = 0;
         while (abort && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n = n + 1;
         end
         if (abort) begin
            $display("Timeout at %0t ns: abort_o stayed high after ack_abort_i", $time);
            timed_out = 1'b1;
         end
      end
      rows_run = rows_run + 1;
      if (is_rd)
         kind = "read ";
      else
         kind = "write";
      if ((errors == err_before) && !timed_out) begin
         res = "ok";
      end else begin
         res = "failed";
         rows_failed = rows_failed + 1;
      end
      $display("row %0d: %s %06o mode %0d -> %s", idx, kind, r.addr, r.mode, res);
   endtask

   //***********************************************************
   // main sequence
   //***********************************************************
   initial begin
      reset       = 1'b1;
      cpu_req     = '0;
      cpu_stb     = 1'b0;
      ack_abort   = 1'b0;
      ifetch      = 1'b0;
      errors      = 0;
      rows_run    = 0;
      rows_failed = 0;
      timed_out   = 1'b0;
      load_table();
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; (i < rows.size()) && !timed_out; i++)
         run_row(i, rows[i]);
      $display("%0d rows run, %0d failed, %0d check errors", rows_run, rows_failed, errors);
      if (timed_out || (rows_failed != 0))
         $display(">>> FAIL");
      else
         $display(">>> PASS");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+tb
hw/mmu_pkg.sv
hw/page_reg_file.sv
hw/page_relocate.sv
hw/access_check.sv
hw/bus_sequencer.sv
hw/mmu_top.sv
tb/mmu_tb.sv
